// ==== rtl/noc_port_pkg.sv ====
/*
 * router port definitions for the five-port mesh switch allocator
 * port codes, port indices and the per-input request format
 */

`default_nettype none

package noc_port_pkg;

        // north, south, west, east, local
        localparam int NUM_PORTS = 5;

        // width of a port code on the request and select paths
        localparam int PORT_CODE_W = 3;

        typedef logic [PORT_CODE_W-1:0] port_code_t;

        // next-hop / source codes, 6 and 7 are illegal
        localparam port_code_t PORT_NONE = 3'd0;
        localparam port_code_t PORT_N    = 3'd1;
        localparam port_code_t PORT_S    = 3'd2;
        localparam port_code_t PORT_W    = 3'd3;
        localparam port_code_t PORT_E    = 3'd4;
        localparam port_code_t PORT_L    = 3'd5;

        // index N=0 .. L=4, always code minus one
        typedef logic [2:0] port_idx_t;

        // request presented by one input port
        typedef struct packed {
                logic       valid;
                port_code_t nexthop;
        } port_req_t;

        // indexed by input port index
        typedef port_req_t [NUM_PORTS-1:0] port_req_vec_t;

        function automatic port_code_t idx_to_code(port_idx_t idx);
                return port_code_t'(idx + 3'd1);
        endfunction

endpackage

`default_nettype wire

// ==== rtl/noc_arb_pkg.sv ====
/*
 * arbitration definitions for the switch allocator
 * request vectors, contender order, pointer reset and crossbar selects
 */

`default_nettype none

package noc_arb_pkg;

        // every output is contended by all inputs but its own
        localparam int NUM_CONTENDERS = noc_port_pkg::NUM_PORTS - 1;

        // one bit per input port index
        typedef logic [noc_port_pkg::NUM_PORTS-1:0] req_vec_t;

        // indexed by output port index
        typedef req_vec_t [noc_port_pkg::NUM_PORTS-1:0] req_matrix_t;

        // slot into the contender list, wraps naturally at four
        typedef logic [$clog2(NUM_CONTENDERS)-1:0] ptr_t;

        // first contender in N, S, W, E, L order
        localparam ptr_t PTR_RESET = '0;

        // crossbar setting of one output
        typedef struct packed {
                logic                     active;
                noc_port_pkg::port_code_t src;
        } xbar_sel_t;

        typedef xbar_sel_t [noc_port_pkg::NUM_PORTS-1:0] xbar_sel_vec_t;

        localparam xbar_sel_t XBAR_SEL_IDLE = '{active: 1'b0, src: noc_port_pkg::PORT_NONE};

        // map a contender slot to an input index, stepping over the own port
        function automatic noc_port_pkg::port_idx_t contender_idx(int unsigned own, ptr_t slot);
                noc_port_pkg::port_idx_t idx;
                idx = noc_port_pkg::port_idx_t'(slot);
                if (int'(slot) >= own) begin
                        idx = idx + 3'd1;
                end
                return idx;
        endfunction

endpackage

`default_nettype wire

// ==== rtl/route_request_decoder.sv ====
/*
 * route request decoder
 * turns each input's next-hop code into one-hot requests per output,
 * dropping U-turns and illegal codes
 */

`default_nettype none

module route_request_decoder (
        input  noc_port_pkg::port_req_vec_t req_i,
        output noc_arb_pkg::req_matrix_t    req_matrix_o
);

        import noc_port_pkg::*;

        // req_matrix_o[k][i] set when input i targets output k
        always_comb begin
                req_matrix_o = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                // no U-turn back into the own port
                                if (req_i[i].valid && (i != k) &&
                                    (req_i[i].nexthop == idx_to_code(port_idx_t'(k)))) begin
                                        req_matrix_o[k][i] = 1'b1;
                                end
                        end
                end
        end

        // upstream route computation is expected to send legal next hops only
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
                logic code_ok;

                assign code_ok = !req_i[i].valid ||
                                 ((req_i[i].nexthop >= PORT_N) &&
                                  (req_i[i].nexthop <= PORT_L) &&
                                  (req_i[i].nexthop != idx_to_code(port_idx_t'(i))));

                always_comb begin
                        a_legal_nexthop: assert final (code_ok)
                        else $warning("input %0d requests illegal next hop %0d, dropped",
                                      i, req_i[i].nexthop);
                end
        end

endmodule

`default_nettype wire

// ==== rtl/rr_output_arbiter.sv ====
/*
 * round-robin arbiter for one output port
 * rotating pointer over four contenders, winner pick, credit gating
 */

`default_nettype none

module rr_output_arbiter #(
        parameter int unsigned OUT_PORT = 0
) (
        input  logic                   clk,
        input  logic                   rst_n_i,
        input  logic                   change_order_i,
        input  logic                   credit_i,
        input  noc_arb_pkg::req_vec_t  req_i,
        output noc_arb_pkg::xbar_sel_t sel_o,
        output noc_arb_pkg::req_vec_t  grant_o
);

        import noc_port_pkg::*;
        import noc_arb_pkg::*;

        ptr_t      ptr_q;
        logic      found;
        port_idx_t win_idx;
        logic      granted;

        // pointer moves only on the strobe, never on a grant
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        ptr_q <= PTR_RESET;
                end else if (change_order_i) begin
                        ptr_q <= ptr_q + 1'b1;
                end
        end

        // first requesting contender from the pointer onward
        always_comb begin
                ptr_t      slot;
                port_idx_t cand;

                found   = 1'b0;
                win_idx = '0;
                for (int off = 0; off < NUM_CONTENDERS; off++) begin
                        slot = ptr_q + ptr_t'(off);
                        cand = contender_idx(OUT_PORT, slot);
                        if (!found && req_i[cand]) begin
                                found   = 1'b1;
                                win_idx = cand;
                        end
                end
        end

        // downstream must have room
        assign granted = found & credit_i;

        always_comb begin
                grant_o = '0;
                sel_o   = XBAR_SEL_IDLE;
                if (granted) begin
                        grant_o[win_idx] = 1'b1;
                        sel_o.active     = 1'b1;
                        sel_o.src        = idx_to_code(win_idx);
                end
        end

        a_no_uturn: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                !grant_o[OUT_PORT]
        ) else $error("output %0d grants its own input", OUT_PORT);

endmodule

`default_nettype wire

// ==== rtl/grant_collector.sv ====
/*
 * grant collector
 * merges per-output grants into one grant per input and registers
 * them with the crossbar selects
 */

`default_nettype none

module grant_collector (
        input  logic                       clk,
        input  logic                       rst_n_i,
        input  noc_arb_pkg::xbar_sel_vec_t arb_sel_i,
        input  noc_arb_pkg::req_matrix_t   arb_grant_i,
        output noc_arb_pkg::xbar_sel_vec_t xbar_sel_o,
        output noc_arb_pkg::req_vec_t      grant_o
);

        import noc_port_pkg::*;
        import noc_arb_pkg::*;

        // by_input[i][k] set when output k grants input i
        req_matrix_t by_input;
        req_vec_t    grant_d;

        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                by_input[i][k] = arb_grant_i[k][i];
                        end
                        grant_d[i] = |by_input[i];
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        grant_o <= '0;
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                xbar_sel_o[k] <= XBAR_SEL_IDLE;
                        end
                end else begin
                        grant_o    <= grant_d;
                        xbar_sel_o <= arb_sel_i;
                end
        end

        // one flit per input per cycle, so arbiters must not collide
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
                a_single_output: assert property (
                        @(posedge clk) disable iff (!rst_n_i)
                        $onehot0(by_input[i])
                ) else $error("input %0d granted by several outputs", i);
        end

endmodule

`default_nettype wire

// ==== rtl/noc_switch_allocator.sv ====
/*
 * switch allocator for one five-port mesh router
 * route decode, one round-robin arbiter per output, registered grants
 */

`default_nettype none

module noc_switch_allocator (
        input  logic                                  clk,
        input  logic                                  rst_n_i,
        input  noc_port_pkg::port_req_vec_t           req_i,
        input  logic [noc_port_pkg::NUM_PORTS-1:0]    credit_i,
        input  logic [noc_port_pkg::NUM_PORTS-1:0]    change_order_i,
        output noc_arb_pkg::xbar_sel_vec_t            xbar_sel_o,
        output noc_arb_pkg::req_vec_t                 grant_o
);

        import noc_port_pkg::*;
        import noc_arb_pkg::*;

        // requests per output
        req_matrix_t   req_matrix;

        // arbiter results, one slice per output
        xbar_sel_vec_t arb_sel;
        req_matrix_t   arb_grant;

        route_request_decoder u_decoder (
                .req_i        (req_i),
                .req_matrix_o (req_matrix)
        );

        for (genvar k = 0; k < NUM_PORTS; k++) begin : g_arb
                rr_output_arbiter #(
                        .OUT_PORT (k)
                ) u_arbiter (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .change_order_i (change_order_i[k]),
                        .credit_i       (credit_i[k]),
                        .req_i          (req_matrix[k]),
                        .sel_o          (arb_sel[k]),
                        .grant_o        (arb_grant[k])
                );
        end

        grant_collector u_collector (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .arb_sel_i   (arb_sel),
                .arb_grant_i (arb_grant),
                .xbar_sel_o  (xbar_sel_o),
                .grant_o     (grant_o)
        );

endmodule

`default_nettype wire

// ==== verif/tb_switch_allocator.sv ====
/*
 * testbench for the five-port switch allocator
 * replays golden vectors and checks registered grants and crossbar selects
 */

`default_nettype none

module tb_switch_allocator;

        timeunit 1ns;
        timeprecision 1ps;

        import noc_port_pkg::*;
        import noc_arb_pkg::*;

        localparam int CLK_PERIOD   = 4;
        localparam int RESET_CYCLES = 10;
        localparam int SLACK_CYCLES = 20;
        localparam int MAX_VEC      = 64;
        localparam int FIELDS       = 5;

        // column order in the golden file
        localparam int F_REQ    = 0;
        localparam int F_CREDIT = 1;
        localparam int F_CHANGE = 2;
        localparam int F_GRANT  = 3;
        localparam int F_XBAR   = 4;

        localparam string GOLDEN_PATH = "verif/switch_alloc_golden.txt";

        logic          clk;
        logic          rst_n_i;
        port_req_vec_t req_i;
        logic [NUM_PORTS-1:0] credit_i;
        logic [NUM_PORTS-1:0] change_order_i;
        xbar_sel_vec_t xbar_sel_o;
        req_vec_t      grant_o;

        // upper nibble stays nonzero in words the file did not fill
        logic [23:0] golden_mem [0:MAX_VEC*FIELDS-1];
        int          num_vec;
        logic        vectors_loaded;

        noc_switch_allocator dut_i (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .req_i          (req_i),
                .credit_i       (credit_i),
                .change_order_i (change_order_i),
                .xbar_sel_o     (xbar_sel_o),
                .grant_o        (grant_o)
        );

        initial clk = 1'b0;

        always #(CLK_PERIOD / 2) clk = ~clk;

        function automatic logic [19:0] golden_field(int v, int f);
                return golden_mem[v * FIELDS + f][19:0];
        endfunction

        // a vector counts only when all five columns were read
        function automatic logic vector_present(int v);
                logic ok;
                ok = 1'b1;
                for (int f = 0; f < FIELDS; f++) begin
                        if (golden_mem[v * FIELDS + f][23:20] != 4'h0) begin
                                ok = 1'b0;
                        end
                end
                return ok;
        endfunction

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("Fail time=%0t signal=%s expected=%h actual=%h",
                                 $time, name, expected, actual);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "mismatch on %s", name);
                end
        endtask

        task automatic load_golden();
                int fd;
                fd = $fopen(GOLDEN_PATH, "r");
                if (fd == 0) begin
                        $display("cannot open the golden vector file %s", GOLDEN_PATH);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "golden file missing");
                end else begin
                        $fclose(fd);
                        for (int i = 0; i < MAX_VEC * FIELDS; i++) begin
                                golden_mem[i] = {4'hf, i[19:0]};
                        end
                        $readmemh(GOLDEN_PATH, golden_mem);
                        while (num_vec < MAX_VEC && vector_present(num_vec)) begin
                                num_vec++;
                        end
                        if (num_vec == 0) begin
                                $display("the golden vector file %s holds no vectors",
                                         GOLDEN_PATH);
                                $display("SOME TESTS FAILED");
                                $fatal(1, "golden file empty");
                        end
                end
        endtask

        task automatic apply_vector(int v);
                logic [19:0] credit_w;
                logic [19:0] change_w;
                credit_w       = golden_field(v, F_CREDIT);
                change_w       = golden_field(v, F_CHANGE);
                req_i          = port_req_vec_t'(golden_field(v, F_REQ));
                credit_i       = credit_w[NUM_PORTS-1:0];
                change_order_i = change_w[NUM_PORTS-1:0];
        endtask

        task automatic check_vector(int v);
                check_value("grant_o", {12'h0, golden_field(v, F_GRANT)}, grant_o);
                check_value("xbar_sel_o", {12'h0, golden_field(v, F_XBAR)}, xbar_sel_o);
        endtask

        initial begin
                rst_n_i        = 1'b0;
                req_i          = '0;
                credit_i       = '0;
                change_order_i = '0;
                vectors_loaded = 1'b0;
                num_vec        = 0;

                load_golden();
                vectors_loaded = 1'b1;

                // load already present while reset is held
                apply_vector(0);
                change_order_i = '0;
                repeat (RESET_CYCLES) begin
                        @(negedge clk);
                        check_value("grant_o", 32'h0, grant_o);
                        check_value("xbar_sel_o", 32'h0, xbar_sel_o);
                end
                rst_n_i = 1'b1;

                // each vector shows up one cycle after it is driven
                for (int v = 0; v < num_vec; v++) begin
                        apply_vector(v);
                        @(negedge clk);
                        check_vector(v);
                end

                $display("ALL TESTS PASSED");
                $finish;
        end

        initial begin
                wait (vectors_loaded);
                #((num_vec + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
                $display("watchdog expired, the run did not finish in time");
                $display("SOME TESTS FAILED");
                $fatal(1, "timeout");
        end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/noc_port_pkg.sv
rtl/noc_arb_pkg.sv
rtl/route_request_decoder.sv
rtl/rr_output_arbiter.sv
rtl/grant_collector.sv
rtl/noc_switch_allocator.sv
verif/tb_switch_allocator.sv

// ==== verif/switch_alloc_golden.txt ====
// columns: req_i credit_i change_order_i expected_grant_o expected_xbar_sel_o (hex)
// req_i and xbar_sel_o digits run L E W S N, one {valid/active, code} nibble each
// all five outputs served at once, also driven during reset
A9DBC 1f 00 1f B9ADC
00000 1f 00 00 00000
// single requests, then U-turn and illegal code
0000C 1f 00 01 09000
000D0 1f 00 02 A0000
00B00 1f 00 00 00000
0F000 1f 00 00 00000
90000 1f 00 10 0000D
// round robin on output W with four contenders
BB0BB 1f 04 01 00900
BB0BB 1f 04 02 00A00
BB0BB 1f 04 08 00C00
BB0BB 1f 04 10 00D00
BB0BB 1f 00 01 00900
// credit low on W holds the pointer
BB0BB 1f 04 01 00900
BB0BB 1b 00 00 00000
BB0BB 1b 00 00 00000
BB0BB 1f 00 02 00A00
// back to back with changing requests
0BC9A 1f 00 0f 0BC9A
C99DD 1f 00 15 9D00B
C99DD 0f 00 14 0D00B
00000 1f 00 00 00000
